// ==== Bender.yml ====
package:
  name: cpci_dma

sources:
  - hw/dma_pkg.sv
  - hw/dma_bus_fsm.sv
  - hw/dma_queue_port.sv
  - hw/dma_rx_select.sv
  - hw/dma_top.sv
  - target: simulation
    files:
      - bench/dma_tb_sva.sv
      - bench/dma_tb.sv

// ==== bench/dma_tb.sv ====
//////////////////////////////////////////////////
// testbench for dma_top, one bridge op at a time
// queue models answer on the falling clock edge
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_tb;

   logic                                        cpci_clk;
   logic                                        reset;
   logic                                        dma_op_req;
   dma_pkg::dma_op_e                            dma_op_code;
   dma_pkg::qid_t                               dma_op_queue;
   logic                                        dma_op_ack;
   logic                                        dma_vld_c2n;
   logic [dma_pkg::data_width-1:0]              dma_data_c2n;
   logic                                        dma_nearly_full_n2c;
   logic                                        dma_vld_n2c;
   logic [dma_pkg::data_width-1:0]              dma_data_n2c;
   logic                                        dma_nearly_full_c2n;
   logic [dma_pkg::num_queues-1:0]              cpu_q_pkt_avail;
   logic [dma_pkg::num_queues-1:0]              cpu_q_rd;
   dma_pkg::cpu_q_word_t [dma_pkg::num_queues-1:0] cpu_q_rd_word;
   logic [dma_pkg::num_queues-1:0]              cpu_q_nearly_full;
   logic [dma_pkg::num_queues-1:0]              cpu_q_wr;
   dma_pkg::cpu_q_word_t [dma_pkg::num_queues-1:0] cpu_q_wr_word;

   // queue models and expected words
   dma_pkg::cpu_q_word_t                        rxq[dma_pkg::num_queues][$];
   dma_pkg::cpu_q_word_t                        exp_tx[dma_pkg::num_queues][$];
   logic [dma_pkg::data_width-1:0]              exp_rx[$];
   logic [dma_pkg::num_queues-1:0]              rd_take;

   logic [31:0] lfsr = 32'h6a7f;
   int          cycles = 0;
   int          limit = 500;
   int          errors = 0;
   int          tests = 0;
   int          failed = 0;
   int          test_err;
   // ack level at the previous falling edge
   logic        ack_d = 1'b0;
   int          pending;

   dma_top u_dma_top (.*);

   initial begin
      cpci_clk = 1'b0;
      forever #4 cpci_clk = ~cpci_clk;
   end

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////

   // galois lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // expected queue word idx of a packet: length word, data, one-hot ctrl at the end
   function automatic dma_pkg::cpu_q_word_t ref_word(input int len, input int idx,
                                                     input logic [31:0] d);
      dma_pkg::cpu_q_word_t w;
      int nb;
      w.data = (idx == 0) ? 32'(len) : d;
      w.ctrl = '0;
      if (idx == (len + 3) / 4) begin
         nb     = (len % 4 == 0) ? 4 : len % 4;
         w.ctrl = 4'b0001 << (nb - 1);
      end
      return w;
   endfunction

   task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("** Error @ %0t: %s got %0h expected %0h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic begin_test();
      test_err = errors;
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors != test_err) failed++;
      $display("test %0d %s: %s", tests, name, (errors == test_err) ? "ok" : "failed");
   endtask

   // waits on the falling edge, the watchdog catches a stuck ack
   task automatic wait_ack(input logic v);
      while (dma_op_ack !== v) @(negedge cpci_clk);
   endtask

   task automatic finish_op();
      @(negedge cpci_clk);
      check("ack held while req high", dma_op_ack, 1'b1);
      dma_op_req = 1'b0;
      wait_ack(1'b0);
   endtask

   //////////////////////////////////////////////////
   // bridge operations
   //////////////////////////////////////////////////

   task automatic run_tx(input int q, input int len, input bit hold);
      logic [31:0] words[$];
      int k;
      int hold_cnt;
      bit held;
      bit saw_nf;
      k        = 0;
      hold_cnt = 0;
      held     = 1'b0;
      saw_nf   = 1'b0;
      words.push_back(32'(len));
      for (int i = 1; i <= (len + 3) / 4; i++) words.push_back(rand_bits(32));
      foreach (words[i]) exp_tx[q].push_back(ref_word(len, i, words[i]));
      limit += 40 * words.size();
      @(negedge cpci_clk);
      dma_op_req   = 1'b1;
      dma_op_code  = dma_pkg::op_tx;
      dma_op_queue = dma_pkg::qid_t'(q);
      while (k < words.size()) begin
         // queue goes nearly full after two words
         if (hold && k == 2 && !held) begin
            held                 = 1'b1;
            cpu_q_nearly_full[q] = 1'b1;
            hold_cnt             = 10;
         end else if (hold_cnt > 0) begin
            hold_cnt--;
            if (hold_cnt == 0) cpu_q_nearly_full[q] = 1'b0;
         end
         if (dma_nearly_full_n2c) begin
            saw_nf      = 1'b1;
            dma_vld_c2n = 1'b0;
         end else begin
            dma_vld_c2n  = 1'b1;
            dma_data_c2n = words[k];
            k++;
         end
         @(negedge cpci_clk);
      end
      dma_vld_c2n          = 1'b0;
      cpu_q_nearly_full[q] = 1'b0;
      wait_ack(1'b1);
      finish_op();
      check("tx words missing", exp_tx[q].size(), 0);
      if (hold) check("nearly_full to bridge", saw_nf, 1'b1);
   endtask

   task automatic run_rx(input int q, input int len, input bit preload, input bit bp);
      dma_pkg::cpu_q_word_t pkt[$];
      logic [31:0] d;
      for (int i = 0; i <= (len + 3) / 4; i++) begin
         d = rand_bits(32);
         pkt.push_back(ref_word(len, i, d));
         exp_rx.push_back(pkt[i].data);
      end
      limit += 40 * pkt.size();
      if (preload) rxq[q] = pkt;
      @(negedge cpci_clk);
      dma_op_req   = 1'b1;
      dma_op_code  = dma_pkg::op_rx;
      dma_op_queue = dma_pkg::qid_t'(q);
      if (!preload) begin
         repeat (20) begin
            @(negedge cpci_clk);
            check("ack on empty queue", dma_op_ack, 1'b0);
         end
         rxq[q] = pkt;
      end
      while (dma_op_ack !== 1'b1) begin
         dma_nearly_full_c2n = bp ? rand_bits(1) : 1'b0;
         @(negedge cpci_clk);
      end
      dma_nearly_full_c2n = 1'b0;
      finish_op();
      check("rx words missing", exp_rx.size(), 0);
      check("rx words left in queue", rxq[q].size(), 0);
   endtask

   //////////////////////////////////////////////////
   // queue models, compare process, watchdog
   //////////////////////////////////////////////////

   // read seen at the clock edge, data shows up in the next cycle
   always @(posedge cpci_clk) begin
      rd_take <= cpu_q_rd;
   end

   always @(negedge cpci_clk) begin
      // every word of the op is already through when ack rises
      if (dma_op_ack === 1'b1 && ack_d !== 1'b1) begin
         pending = exp_rx.size();
         for (int q = 0; q < dma_pkg::num_queues; q++) pending += exp_tx[q].size();
         check("words still due at ack rise", pending, 0);
      end
      // ack only drops once req is gone
      if (dma_op_ack === 1'b0 && ack_d === 1'b1) begin
         check("req at ack fall", dma_op_req, 1'b0);
      end
      ack_d = dma_op_ack;
      for (int q = 0; q < dma_pkg::num_queues; q++) begin
         if (rd_take[q] === 1'b1) begin
            if (rxq[q].size() == 0) begin
               $display("read from empty rx queue %0d at %0t", q, $time);
               errors++;
            end else begin
               cpu_q_rd_word[q] = rxq[q].pop_front();
            end
         end
         cpu_q_pkt_avail[q] = rxq[q].size() != 0;
         if (cpu_q_wr[q] === 1'b1) begin
            if (exp_tx[q].size() == 0) begin
               $display("unexpected write to tx queue %0d at %0t", q, $time);
               errors++;
            end else begin
               check($sformatf("tx queue %0d word", q), cpu_q_wr_word[q], exp_tx[q].pop_front());
            end
         end
      end
      if (dma_vld_n2c === 1'b1) begin
         if (exp_rx.size() == 0) begin
            $display("extra rx word to bridge at %0t", $time);
            errors++;
         end else begin
            check("rx word to bridge", dma_data_n2c, exp_rx.pop_front());
         end
      end
   end

   always @(posedge cpci_clk) begin
      cycles++;
      if (cycles > limit) begin
         $display("run stopped after %0d cycles, an operation never finished", cycles);
         $display("TESTS FAILED");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////

   initial begin
      reset               = 1'b1;
      dma_op_req          = 1'b0;
      dma_op_code         = dma_pkg::op_none;
      dma_op_queue        = '0;
      dma_vld_c2n         = 1'b0;
      dma_data_c2n        = '0;
      dma_nearly_full_c2n = 1'b0;
      cpu_q_pkt_avail     = '0;
      cpu_q_nearly_full   = '0;
      cpu_q_rd_word       = '0;
      rd_take             = '0;

      begin_test();
      repeat (5) begin
         @(negedge cpci_clk);
         check("outputs in reset", {dma_op_ack, dma_vld_n2c, cpu_q_wr, cpu_q_rd,
                                    dma_nearly_full_n2c}, '0);
      end
      reset = 1'b0;
      @(negedge cpci_clk);
      check("outputs after reset", {dma_op_ack, dma_vld_n2c, cpu_q_wr, cpu_q_rd,
                                    dma_nearly_full_n2c}, '0);
      end_test("reset state");

      begin_test();
      for (int q = 0; q < dma_pkg::num_queues; q++) begin
         for (int len = 1; len <= 9; len++) run_tx(q, len, 1'b0);
      end
      end_test("tx lengths 1 to 9");

      begin_test();
      for (int q = 0; q < dma_pkg::num_queues; q++) begin
         repeat (2) run_tx(q, 1 + rand_bits(6), 1'b0);
      end
      end_test("tx random lengths");

      begin_test();
      for (int q = 0; q < dma_pkg::num_queues; q++) run_rx(q, 1 + rand_bits(6), 1'b1, 1'b0);
      end_test("rx packets");

      begin_test();
      run_rx(2, 1 + rand_bits(6), 1'b0, 1'b0);
      end_test("rx on empty queue");

      begin_test();
      for (int q = 0; q < dma_pkg::num_queues; q++) run_rx(q, 1 + rand_bits(6), 1'b1, 1'b1);
      end_test("rx back-pressure");

      begin_test();
      run_tx(1, 40, 1'b1);
      end_test("tx back-pressure");

      repeat (5) @(negedge cpci_clk);
      $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== bench/dma_tb_sva.sv ====
//////////////////////////////////////////////////
// protocol assertions bound into dma_top
// op code and queue are held while req is high
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_tb_sva (
   input logic                           cpci_clk,
   input logic                           reset,
   input logic                           dma_op_req,
   input dma_pkg::dma_op_e               dma_op_code,
   input logic                           dma_op_ack,
   input logic                           dma_vld_n2c,
   input logic [dma_pkg::num_queues-1:0] cpu_q_wr,
   input logic [dma_pkg::num_queues-1:0] cpu_q_rd
);

   // ack only answers a pending req
   a_ack_needs_req: assert property (@(posedge cpci_clk) disable iff (reset)
      $rose(dma_op_ack) |-> dma_op_req)
      else $error("ack rose without req");

   // one queue at a time in each direction
   a_wr_onehot: assert property (@(posedge cpci_clk) disable iff (reset)
      $onehot0(cpu_q_wr))
      else $error("more than one cpu_q_wr");

   a_rd_onehot: assert property (@(posedge cpci_clk) disable iff (reset)
      $onehot0(cpu_q_rd))
      else $error("more than one cpu_q_rd");

   // rx words only inside an rx operation
   a_rx_vld_in_op: assert property (@(posedge cpci_clk) disable iff (reset)
      $rose(dma_vld_n2c) |-> (dma_op_req && dma_op_code == dma_pkg::op_rx))
      else $error("rx word outside an rx op");

endmodule

bind dma_top dma_tb_sva u_dma_tb_sva (.*);

// ==== hw/dma_bus_fsm.sv ====
//////////////////////////////////////////////////
// bridge side of the dma, one operation at a time
// tx words may start in the same cycle as req
// a zero byte length is not supported
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_bus_fsm (
   input  logic                                cpci_clk,
   input  logic                                reset,
   // bridge operation handshake
   input  logic                                dma_op_req,
   input  dma_pkg::dma_op_e                    dma_op_code,
   input  dma_pkg::qid_t                       dma_op_queue,
   output logic                                dma_op_ack,
   // tx words from the bridge
   input  logic                                dma_vld_c2n,
   input  logic [dma_pkg::data_width-1:0]      dma_data_c2n,
   output logic                                dma_nearly_full_n2c,
   // rx words to the bridge
   output logic                                dma_vld_n2c,
   output logic [dma_pkg::data_width-1:0]      dma_data_n2c,
   input  logic                                dma_nearly_full_c2n,
   // queue status
   input  logic [dma_pkg::num_queues-1:0]      cpu_q_pkt_avail,
   input  logic [dma_pkg::num_queues-1:0]      cpu_q_nearly_full,
   // to the queue ports
   output dma_pkg::cpci_word_t                 tx_word,
   output logic [dma_pkg::num_queues-1:0]      tx_vld,
   // to and from the rx selector
   output logic                                rx_want,
   output dma_pkg::qid_t                       rx_queue,
   input  dma_pkg::cpci_word_t                 sel_word,
   input  logic                                sel_vld
);

   dma_pkg::fsm_state_e              state;
   dma_pkg::qid_t                    op_queue_r;
   logic                             first_r;
   logic                             avail_seen_r;
   logic [dma_pkg::len_width-1:0]    bytes_left_r;
   logic                             tx_active;
   logic                             tx_take;
   logic                             first_now;
   logic                             tx_last;
   logic                             rx_last;
   dma_pkg::qid_t                    tx_q;

   // tx words count from the req cycle on
   assign tx_active = (state == dma_pkg::st_tx) ||
                      (state == dma_pkg::st_idle && dma_op_req &&
                       dma_op_code == dma_pkg::op_tx);
   assign tx_take   = tx_active && dma_vld_c2n;
   // queue not latched yet while still idle
   assign tx_q      = (state == dma_pkg::st_idle) ? dma_op_queue : op_queue_r;
   assign first_now = (state == dma_pkg::st_idle) || first_r;
   // final data word once 4 or fewer bytes remain
   assign tx_last   = !first_now && (bytes_left_r <= dma_pkg::word_bytes);

   // last rx word seen at the selector output
   assign rx_last   = sel_vld && sel_word.last;
   // reads stop on back-pressure and on the last word
   assign rx_want   = (state == dma_pkg::st_rx) && avail_seen_r &&
                      !dma_nearly_full_c2n && !rx_last;
   assign rx_queue  = op_queue_r;

   //////////////////////////////////////////////////
   // operation fsm and byte counter
   //////////////////////////////////////////////////

   always_ff @(posedge cpci_clk) begin
      if (reset) begin
         state        <= dma_pkg::st_idle;
         op_queue_r   <= '0;
         first_r      <= 1'b1;
         avail_seen_r <= 1'b0;
         bytes_left_r <= '0;
         dma_op_ack   <= 1'b0;
      end else begin
         case (state)
            dma_pkg::st_idle: begin
               first_r      <= 1'b1;
               avail_seen_r <= 1'b0;
               if (dma_op_req) begin
                  op_queue_r <= dma_op_queue;
                  case (dma_op_code)
                     dma_pkg::op_tx: state <= dma_pkg::st_tx;
                     dma_pkg::op_rx: state <= dma_pkg::st_rx;
                     // nothing to move, just ack
                     default:        state <= dma_pkg::st_done;
                  endcase
               end
            end
            dma_pkg::st_tx: begin
               if (tx_take && tx_last) begin
                  state <= dma_pkg::st_done;
               end
            end
            dma_pkg::st_rx: begin
               // wait here until the queue holds a packet
               if (cpu_q_pkt_avail[op_queue_r]) begin
                  avail_seen_r <= 1'b1;
               end
               if (rx_last) begin
                  state <= dma_pkg::st_done;
               end
            end
            dma_pkg::st_done: begin
               // four-phase: raise ack, drop it once req is gone
               if (!dma_op_ack) begin
                  // last tx word must pass the port register first
                  if (tx_vld == '0) begin
                     dma_op_ack <= 1'b1;
                  end
               end else if (!dma_op_req) begin
                  dma_op_ack <= 1'b0;
                  state      <= dma_pkg::st_idle;
               end
            end
            default: state <= dma_pkg::st_idle;
         endcase

         // length word loads the counter, data words drain it
         if (tx_take) begin
            if (first_now) begin
               bytes_left_r <= dma_data_c2n[dma_pkg::len_width-1:0];
               first_r      <= 1'b0;
            end else begin
               bytes_left_r <= bytes_left_r - dma_pkg::word_bytes;
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // word registers in both directions
   //////////////////////////////////////////////////

   always_ff @(posedge cpci_clk) begin
      if (reset) begin
         tx_vld              <= '0;
         dma_vld_n2c         <= 1'b0;
         dma_nearly_full_n2c <= 1'b0;
      end else begin
         // steer to the active queue only
         tx_vld <= '0;
         if (tx_take) begin
            tx_vld[tx_q] <= 1'b1;
         end
         dma_vld_n2c         <= sel_vld && (state == dma_pkg::st_rx);
         dma_nearly_full_n2c <= cpu_q_nearly_full[tx_q];
      end
   end

   // payload, qualified by the valid bits above
   always_ff @(posedge cpci_clk) begin
      tx_word.data        <= dma_data_c2n;
      tx_word.last        <= tx_last;
      // remaining count mod 4, so 4 bytes encodes as 0
      tx_word.valid_bytes <= tx_last ? bytes_left_r[1:0] : 2'd0;
      dma_data_n2c        <= sel_word.data;
   end

endmodule

// ==== hw/dma_pkg.sv ====
//////////////////////////////////////////////////
// shared widths, enums and word structs for the dma
// packet lengths are 1 to 2047 bytes, length in word 0
// ctrl on the last queue word: bit n-1 set for n bytes
//////////////////////////////////////////////////

package dma_pkg;

   //////////////////////////////////////////////////
   // sizes
   //////////////////////////////////////////////////

   // cpu queue pairs, one tx and one rx each
   localparam int num_queues = 4;
   localparam int data_width = 32;
   // one ctrl bit per byte lane
   localparam int ctrl_width = data_width / 8;
   // byte length field in the first word
   localparam int len_width  = 11;
   localparam int qid_width  = 2;

   // bytes carried by a full word, sized for the length counter
   localparam logic [len_width-1:0] word_bytes = len_width'(data_width / 8);

   //////////////////////////////////////////////////
   // enums
   //////////////////////////////////////////////////

   // bridge operation codes
   typedef enum logic [1:0] {
      op_none = 2'b00,
      op_tx   = 2'b01,
      op_rx   = 2'b10
   } dma_op_e;

   // bus fsm states
   typedef enum logic [1:0] {
      st_idle = 2'b00,
      st_tx   = 2'b01,
      st_rx   = 2'b10,
      st_done = 2'b11
   } fsm_state_e;

   typedef logic [qid_width-1:0] qid_t;

   //////////////////////////////////////////////////
   // words
   //////////////////////////////////////////////////

   // bridge-side word, valid_bytes of 0 means all 4
   typedef struct packed {
      logic [data_width-1:0] data;
      logic                  last;
      logic [1:0]            valid_bytes;
   } cpci_word_t;

   // queue-side word, ctrl zero except on the last word
   typedef struct packed {
      logic [ctrl_width-1:0] ctrl;
      logic [data_width-1:0] data;
   } cpu_q_word_t;

endpackage

// ==== hw/dma_queue_port.sv ====
//////////////////////////////////////////////////
// one cpu queue pair, tx writer and rx reader
// queue read data must follow cpu_q_rd by one cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_queue_port (
   input  logic                  cpci_clk,
   input  logic                  reset,
   // tx word from the bus fsm
   input  dma_pkg::cpci_word_t   tx_word,
   input  logic                  tx_vld,
   // tx queue write side
   output logic                  cpu_q_wr,
   output dma_pkg::cpu_q_word_t  cpu_q_wr_word,
   // rx queue read side
   input  logic                  rx_en,
   output logic                  cpu_q_rd,
   input  dma_pkg::cpu_q_word_t  cpu_q_rd_word,
   // rx word to the selector
   output dma_pkg::cpci_word_t   rx_word,
   output logic                  rx_vld
);

   logic rd_pend_r;
   logic done_r;
   logic word_last;

   //////////////////////////////////////////////////
   // ctrl coding
   //////////////////////////////////////////////////

   // valid byte count to one-hot ctrl, 0 wraps to bit 3
   function automatic logic [dma_pkg::ctrl_width-1:0] vb_to_ctrl(input logic [1:0] vb);
      logic [1:0] pos;
      pos = vb - 2'd1;
      return {{(dma_pkg::ctrl_width-1){1'b0}}, 1'b1} << pos;
   endfunction

   // one-hot ctrl back to a count, 4 bytes as 0
   function automatic logic [1:0] ctrl_to_vb(input logic [dma_pkg::ctrl_width-1:0] ctrl);
      logic [1:0] vb;
      vb = 2'd0;
      if (ctrl[0]) vb = 2'd1;
      if (ctrl[1]) vb = 2'd2;
      if (ctrl[2]) vb = 2'd3;
      return vb;
   endfunction

   //////////////////////////////////////////////////
   // tx writer
   //////////////////////////////////////////////////

   always_ff @(posedge cpci_clk) begin
      if (reset) begin
         cpu_q_wr <= 1'b0;
      end else begin
         cpu_q_wr <= tx_vld;
      end
   end

   always_ff @(posedge cpci_clk) begin
      cpu_q_wr_word.data <= tx_word.data;
      // ctrl stays zero until the last word
      cpu_q_wr_word.ctrl <= tx_word.last ? vb_to_ctrl(tx_word.valid_bytes) : '0;
   end

   //////////////////////////////////////////////////
   // rx reader
   //////////////////////////////////////////////////

   // returning word closes the packet
   assign word_last = rd_pend_r && (cpu_q_rd_word.ctrl != '0);

   // no read past the last word, even back to back
   assign cpu_q_rd = rx_en && !done_r && !word_last;

   // read data lands one cycle after the read
   assign rx_vld = rd_pend_r;

   always_comb begin
      rx_word.data        = cpu_q_rd_word.data;
      rx_word.last        = cpu_q_rd_word.ctrl != '0;
      rx_word.valid_bytes = ctrl_to_vb(cpu_q_rd_word.ctrl);
   end

   always_ff @(posedge cpci_clk) begin
      if (reset) begin
         rd_pend_r <= 1'b0;
         done_r    <= 1'b0;
      end else begin
         rd_pend_r <= cpu_q_rd;
         // packet over until the fsm lets go of rx_en
         if (!rx_en) begin
            done_r <= 1'b0;
         end else if (word_last) begin
            done_r <= 1'b1;
         end
      end
   end

endmodule

// ==== hw/dma_rx_select.sv ====
//////////////////////////////////////////////////
// rx selector between the queue ports and the bus fsm
// at most one read outstanding per port
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_rx_select (
   input  logic                                        cpci_clk,
   input  logic                                        reset,
   // request from the bus fsm
   input  logic                                        rx_want,
   input  dma_pkg::qid_t                               rx_queue,
   // queue port side
   output logic [dma_pkg::num_queues-1:0]              rx_en,
   input  dma_pkg::cpci_word_t [dma_pkg::num_queues-1:0] rx_word,
   input  logic [dma_pkg::num_queues-1:0]              rx_vld,
   // registered word to the bus fsm
   output dma_pkg::cpci_word_t                         sel_word,
   output logic                                        sel_vld
);

   dma_pkg::qid_t held_q_r;
   logic          wait_r;
   dma_pkg::qid_t cur_q;

   // one port enabled at a time
   always_comb begin
      rx_en = '0;
      for (int i = 0; i < dma_pkg::num_queues; i++) begin
         rx_en[i] = rx_want && (rx_queue == dma_pkg::qid_t'(i));
      end
   end

   // keep the old queue one cycle after want drops,
   // its last read may still be returning
   assign cur_q = (rx_want || !wait_r) ? rx_queue : held_q_r;

   //////////////////////////////////////////////////
   // selection state
   //////////////////////////////////////////////////

   always_ff @(posedge cpci_clk) begin
      if (reset) begin
         held_q_r <= '0;
         wait_r   <= 1'b0;
         sel_vld  <= 1'b0;
      end else begin
         held_q_r <= cur_q;
         // a read may have gone out this cycle
         wait_r   <= rx_want;
         sel_vld  <= rx_vld[cur_q];
      end
   end

   // payload only
   always_ff @(posedge cpci_clk) begin
      sel_word <= rx_word[cur_q];
   end

endmodule

// ==== hw/dma_top.sv ====
//////////////////////////////////////////////////
// cpci packet dma top, four cpu queue pairs
// single clock domain on cpci_clk
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_top (
   input  logic                                          cpci_clk,
   input  logic                                          reset,
   // bridge operation
   input  logic                                          dma_op_req,
   input  dma_pkg::dma_op_e                              dma_op_code,
   input  dma_pkg::qid_t                                 dma_op_queue,
   output logic                                          dma_op_ack,
   // tx from the bridge
   input  logic                                          dma_vld_c2n,
   input  logic [dma_pkg::data_width-1:0]                dma_data_c2n,
   output logic                                          dma_nearly_full_n2c,
   // rx to the bridge
   output logic                                          dma_vld_n2c,
   output logic [dma_pkg::data_width-1:0]                dma_data_n2c,
   input  logic                                          dma_nearly_full_c2n,
   // cpu rx queues
   input  logic [dma_pkg::num_queues-1:0]                cpu_q_pkt_avail,
   output logic [dma_pkg::num_queues-1:0]                cpu_q_rd,
   input  dma_pkg::cpu_q_word_t [dma_pkg::num_queues-1:0] cpu_q_rd_word,
   // cpu tx queues
   input  logic [dma_pkg::num_queues-1:0]                cpu_q_nearly_full,
   output logic [dma_pkg::num_queues-1:0]                cpu_q_wr,
   output dma_pkg::cpu_q_word_t [dma_pkg::num_queues-1:0] cpu_q_wr_word
);

   // fsm to ports
   dma_pkg::cpci_word_t                         tx_word;
   logic [dma_pkg::num_queues-1:0]              tx_vld;
   // fsm to selector
   logic                                        rx_want;
   dma_pkg::qid_t                               rx_queue;
   // selector and ports
   logic [dma_pkg::num_queues-1:0]              rx_en;
   dma_pkg::cpci_word_t [dma_pkg::num_queues-1:0] rx_word;
   logic [dma_pkg::num_queues-1:0]              rx_vld;
   // selector back to fsm
   dma_pkg::cpci_word_t                         sel_word;
   logic                                        sel_vld;

   dma_bus_fsm u_dma_bus_fsm (
      .cpci_clk            (cpci_clk),
      .reset               (reset),
      .dma_op_req          (dma_op_req),
      .dma_op_code         (dma_op_code),
      .dma_op_queue        (dma_op_queue),
      .dma_op_ack          (dma_op_ack),
      .dma_vld_c2n         (dma_vld_c2n),
      .dma_data_c2n        (dma_data_c2n),
      .dma_nearly_full_n2c (dma_nearly_full_n2c),
      .dma_vld_n2c         (dma_vld_n2c),
      .dma_data_n2c        (dma_data_n2c),
      .dma_nearly_full_c2n (dma_nearly_full_c2n),
      .cpu_q_pkt_avail     (cpu_q_pkt_avail),
      .cpu_q_nearly_full   (cpu_q_nearly_full),
      .tx_word             (tx_word),
      .tx_vld              (tx_vld),
      .rx_want             (rx_want),
      .rx_queue            (rx_queue),
      .sel_word            (sel_word),
      .sel_vld             (sel_vld)
   );

   // one port per queue pair
   for (genvar i = 0; i < dma_pkg::num_queues; i++) begin : g_queue
      dma_queue_port u_dma_queue_port (
         .cpci_clk      (cpci_clk),
         .reset         (reset),
         .tx_word       (tx_word),
         .tx_vld        (tx_vld[i]),
         .cpu_q_wr      (cpu_q_wr[i]),
         .cpu_q_wr_word (cpu_q_wr_word[i]),
         .rx_en         (rx_en[i]),
         .cpu_q_rd      (cpu_q_rd[i]),
         .cpu_q_rd_word (cpu_q_rd_word[i]),
         .rx_word       (rx_word[i]),
         .rx_vld        (rx_vld[i])
      );
   end

   dma_rx_select u_dma_rx_select (
      .cpci_clk (cpci_clk),
      .reset    (reset),
      .rx_want  (rx_want),
      .rx_queue (rx_queue),
      .rx_en    (rx_en),
      .rx_word  (rx_word),
      .rx_vld   (rx_vld),
      .sel_word (sel_word),
      .sel_vld  (sel_vld)
   );

endmodule

// ==== vlog.f ====
hw/dma_pkg.sv
hw/dma_bus_fsm.sv
hw/dma_queue_port.sv
hw/dma_rx_select.sv
hw/dma_top.sv
bench/dma_tb_sva.sv
bench/dma_tb.sv
